/* project.f */
source/axi_rd_pkg.sv
source/video_pkg.sv
source/mm2fifo.sv
source/sync_fifo.sv
source/word_unpacker.sv
source/frame_reader_top.sv
tb/axi_ram_model.sv
tb/tb_frame_reader.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the frame reader simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module tb_frame_reader -o sim_frame_reader
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_frame_reader)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
	exit 0
fi
echo "pass message not found"
exit 1

/* tb/tb_frame_reader.sv */
// Frame reader testbench
`timescale 1ns/1ps

module tb_frame_reader import axi_rd_pkg::*, video_pkg::*; ();

	logic                  M_AXI_ACLK;
	logic                  M_AXI_ARESETN;
	logic                  fsync;
	logic                  frame_pulse;
	logic [img_wbits-1:0]  img_width;
	logic [img_hbits-1:0]  img_height;
	logic [addr_width-1:0] base_addr;
	axi_ar_t               ar;
	logic                  ar_valid;
	logic                  ar_ready;
	axi_r_t                r;
	logic                  r_valid;
	logic                  r_ready;
	pixel_t                pix;
	logic                  pix_valid;
	logic                  fast;

	int   errors;
	int   tests_passed;
	int   tests_failed;
	int   start_err;
	int   ar_start;
	int   pulse_start;
	int   pix_idx;
	int   frames_seen;
	int   ar_idx;
	int   ar_count;
	int   pulse_count;
	int   beat_cnt;
	logic frame_idle;
	logic saw_stall;
	logic ar_valid_prev;
	logic [1:0] pulse_hist;
	logic timed_out;

	frame_reader_top dut0 (
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.fsync         (fsync),
		.frame_pulse   (frame_pulse),
		.img_width     (img_width),
		.img_height    (img_height),
		.base_addr     (base_addr),
		.ar            (ar),
		.ar_valid      (ar_valid),
		.ar_ready      (ar_ready),
		.r             (r),
		.r_valid       (r_valid),
		.r_ready       (r_ready),
		.pix           (pix),
		.pix_valid     (pix_valid)
	);

	axi_ram_model mem0 (
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.fast          (fast),
		.ar            (ar),
		.ar_valid      (ar_valid),
		.ar_ready      (ar_ready),
		.r             (r),
		.r_valid       (r_valid),
		.r_ready       (r_ready)
	);

	always #20 M_AXI_ACLK = ~M_AXI_ACLK;

	task automatic log_error(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic note_timeout(input string msg);
		$display("timeout: %s", msg);
		errors++;
		timed_out = 1'b1;
	endtask

	// --------------------------------------------------
	// Protocol checks
	// --------------------------------------------------
	assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		frame_pulse |=> !frame_pulse)
		else log_error("frame_pulse longer than one cycle");

	assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar.addr))
		else log_error("ar dropped or changed before ar_ready");

	// Everything is stable at the falling edge
	always @(negedge M_AXI_ACLK) begin
		int w;
		int h;
		w = int'(img_width);
		h = int'(img_height);
		if (!M_AXI_ARESETN) begin
			pix_idx = 0;
			frames_seen = 0;
			ar_idx = 0;
			ar_count = 0;
			pulse_count = 0;
			beat_cnt = 0;
			frame_idle = 1'b1;
			saw_stall = 1'b0;
			ar_valid_prev = 1'b0;
			pulse_hist = 2'b00;
		end else begin
			if (pix_valid) begin
				assert (pix.data == 8'((base_addr + 32'(pix_idx)) * 32'd7))
					else log_error($sformatf("pixel %0d data %h", pix_idx, pix.data));
				assert (pix.sof == (pix_idx == 0))
					else log_error($sformatf("pixel %0d sof %b", pix_idx, pix.sof));
				assert (pix.eol == ((pix_idx % w) == (w - 1)))
					else log_error($sformatf("pixel %0d eol %b", pix_idx, pix.eol));
				pix_idx++;
				if (pix_idx == w * h) begin
					pix_idx = 0;
					frames_seen++;
				end
			end
			if (ar_valid && ar_ready) begin
				assert (ar.len == 8'd15 && ar.size == 3'd2 && ar.burst == 2'b01)
					else log_error("ar len, size or burst field wrong");
				assert (!ar.lock && ar.cache == 4'h0 && ar.prot == 3'h0 && ar.qos == 4'h0)
					else log_error("ar lock, cache, prot or qos not zero");
				assert (ar.addr == base_addr + 32'(ar_idx * 64))
					else log_error($sformatf("burst %0d address %h", ar_idx, ar.addr));
				ar_idx++;
				ar_count++;
			end
			if (r_valid && !r_ready)
				saw_stall = 1'b1;
			if (r_valid && r_ready) begin
				beat_cnt++;
				if (beat_cnt == w * h / 4) begin
					assert (ar_idx == w * h / 64)
						else log_error($sformatf("frame used %0d bursts", ar_idx));
					beat_cnt = 0;
					frame_idle = 1'b1;
				end
			end
			assert (!(frame_idle && ar_valid))
				else log_error("ar_valid high while waiting for a frame request");
			assert (!pulse_hist[1] || (ar_valid && !ar_valid_prev))
				else log_error("ar_valid did not rise two cycles after frame_pulse");
			if (frame_pulse) begin
				assert (fsync) else log_error("frame_pulse without fsync");
				pulse_count++;
				frame_idle = 1'b0;
				ar_idx = 0;
			end
			pulse_hist = {pulse_hist[0], frame_pulse};
			ar_valid_prev = ar_valid;
		end
	end

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	task automatic request_frame(input logic [31:0] base, input int w, input int h,
			input logic no_stall);
		@(posedge M_AXI_ACLK);
		#2;
		base_addr = base;
		img_width = img_wbits'(w);
		img_height = img_hbits'(h);
		fast = no_stall;
		fsync = 1'b1;
	endtask

	task automatic wait_pulses(input int target);
		int n;
		n = 0;
		while (pulse_count < target && !timed_out) begin
			@(posedge M_AXI_ACLK);
			n++;
			if (n > 300)
				note_timeout("no frame_pulse after a frame request");
		end
	endtask

	task automatic wait_frames(input int target);
		int n;
		n = 0;
		while (frames_seen < target && !timed_out) begin
			@(posedge M_AXI_ACLK);
			n++;
			if (n > 3000)
				note_timeout("frame pixels did not all arrive");
		end
	endtask

	task automatic close_test(input string name);
		if (errors == start_err) begin
			tests_passed++;
			$display("test %s passed", name);
		end else begin
			tests_failed++;
			$display("test %s failed", name);
		end
	endtask

	initial begin
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		M_AXI_ACLK = 1'b0;
		M_AXI_ARESETN = 1'b0;
		fsync = 1'b0;
		img_width = '0;
		img_height = '0;
		base_addr = '0;
		fast = 1'b0;
		repeat (2) @(posedge M_AXI_ACLK);
		#2;
		M_AXI_ARESETN = 1'b1;

		// Frame A with random stalls
		start_err = errors;
		request_frame(32'h0000_1000, 16, 8, 1'b0);
		wait_pulses(1);
		#2;
		fsync = 1'b0;
		wait_frames(1);
		if (!timed_out) begin
			assert (ar_count == 2 && pulse_count == 1 && pix_idx == 0)
				else log_error($sformatf("frame A bursts %0d pulses %0d", ar_count, pulse_count));
			close_test("frame_a");
		end

		// Frame B twice back to back, no stalls so the FIFO fills
		if (!timed_out) begin
			start_err = errors;
			ar_start = ar_count;
			pulse_start = pulse_count;
			request_frame(32'h0000_2040, 32, 4, 1'b1);
			wait_pulses(3);
			#2;
			fsync = 1'b0;
			wait_frames(3);
		end
		if (!timed_out) begin
			assert (ar_count - ar_start == 4 && pulse_count - pulse_start == 2
					&& pix_idx == 0)
				else log_error($sformatf("frame B bursts %0d pulses %0d",
					ar_count - ar_start, pulse_count - pulse_start));
			assert (saw_stall)
				else begin
					$display("r_ready never went low while the FIFO was filling");
					errors++;
				end
			close_test("frame_b_backpressure");
		end

		// No request, so the bus stays quiet
		if (!timed_out) begin
			start_err = errors;
			ar_start = ar_count;
			pulse_start = pulse_count;
			repeat (40) @(posedge M_AXI_ACLK);
			assert (ar_count == ar_start && pulse_count == pulse_start)
				else log_error("bus activity without a frame request");
			close_test("idle");
		end

		$display("tests passed %0d failed %0d errors %0d", tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0 && !timed_out)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* tb/axi_ram_model.sv */
// AXI read memory model
`timescale 1ns/1ps

module axi_ram_model import axi_rd_pkg::*; (
	input  logic    M_AXI_ACLK,
	input  logic    M_AXI_ARESETN,
	input  logic    fast,

	input  axi_ar_t ar,
	input  logic    ar_valid,
	output logic    ar_ready,

	output axi_r_t  r,
	output logic    r_valid,
	input  logic    r_ready
);

	logic [31:0] lfsr_state;
	logic [31:0] addr;
	logic [31:0] ar_addr_s;
	int          beats_left;
	int          wait_cnt;
	logic        rst_n_s;
	logic        ar_seen;
	logic        ar_fire;
	logic        r_fire;
	logic        in_data;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// Stall of 0 to 3 cycles, one LFSR step per bit
	function automatic int draw_stall();
		int n;
		int i;
		n = 0;
		if (fast)
			return 0;
		for (i = 0; i < 2; i++) begin
			n = (n << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);
		end
		return n;
	endfunction

	// Byte at address a holds a times 7
	function automatic logic [31:0] pattern_word(input logic [31:0] a);
		logic [31:0] w;
		int k;
		for (k = 0; k < 4; k++)
			w[k*8 +: 8] = 8'((a + 32'(k)) * 32'd7);
		return w;
	endfunction

	// --------------------------------------------------
	// Slave sequencing
	// --------------------------------------------------
	initial begin
		lfsr_state = 32'h7350_afcb;
		ar_ready = 1'b0;
		r_valid = 1'b0;
		r = '0;
		addr = '0;
		beats_left = 0;
		wait_cnt = 0;
		in_data = 1'b0;
		forever begin
			// Handshakes are settled by the falling edge
			@(negedge M_AXI_ACLK);
			rst_n_s = M_AXI_ARESETN;
			ar_fire = ar_valid && ar_ready;
			r_fire = r_valid && r_ready;
			ar_seen = ar_valid;
			ar_addr_s = ar.addr;
			@(posedge M_AXI_ACLK);
			#2;
			if (!rst_n_s) begin
				ar_ready = 1'b0;
				r_valid = 1'b0;
				in_data = 1'b0;
				wait_cnt = 0;
			end else if (!in_data) begin
				if (ar_fire) begin
					ar_ready = 1'b0;
					addr = {ar_addr_s[31:2], 2'b00};
					beats_left = burst_len;
					in_data = 1'b1;
					wait_cnt = draw_stall();
				end else if (ar_seen && !ar_ready) begin
					if (wait_cnt == 0)
						ar_ready = 1'b1;
					else
						wait_cnt--;
				end
			end
			if (in_data) begin
				if (r_fire) begin
					addr += 32'd4;
					beats_left--;
					r_valid = 1'b0;
					wait_cnt = draw_stall();
					if (beats_left == 0)
						in_data = 1'b0;
				end
				if (in_data && !r_valid) begin
					if (wait_cnt == 0) begin
						r_valid = 1'b1;
						r = '{data: pattern_word(addr), resp: 2'b00, last: (beats_left == 1)};
					end else begin
						wait_cnt--;
					end
				end
			end
		end
	end

endmodule

/* source/frame_reader_top.sv */
// Video frame reader top level
`timescale 1ns/1ps

module frame_reader_top import axi_rd_pkg::*, video_pkg::*; (
	input  logic                  M_AXI_ACLK,
	input  logic                  M_AXI_ARESETN,

	// Frame control
	input  logic                  fsync,
	output logic                  frame_pulse,
	input  logic [img_wbits-1:0]  img_width,
	input  logic [img_hbits-1:0]  img_height,
	input  logic [addr_width-1:0] base_addr,

	// AXI read address
	output axi_ar_t               ar,
	output logic                  ar_valid,
	input  logic                  ar_ready,

	// AXI read data
	input  axi_r_t                r,
	input  logic                  r_valid,
	output logic                  r_ready,

	// Pixel stream
	output pixel_t                pix,
	output logic                  pix_valid
);

	// --------------------------------------------------
	// FIFO hookup
	// --------------------------------------------------
	fifo_word_t fifo_in;
	fifo_word_t fifo_out;
	logic       fifo_wr;
	logic       fifo_rd;
	logic       full;
	logic       empty;

	mm2fifo reader0 (
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.img_width     (img_width),
		.img_height    (img_height),
		.base_addr     (base_addr),
		.fsync         (fsync),
		.frame_pulse   (frame_pulse),
		.ar            (ar),
		.ar_valid      (ar_valid),
		.ar_ready      (ar_ready),
		.r             (r),
		.r_valid       (r_valid),
		.r_ready       (r_ready),
		.fifo_in       (fifo_in),
		.fifo_wr       (fifo_wr),
		.full          (full)
	);

	sync_fifo #(
		.depth (fifo_depth)
	) fifo0 (
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.wr            (fifo_wr),
		.din           (fifo_in),
		.rd            (fifo_rd),
		.dout          (fifo_out),
		.full          (full),
		.empty         (empty)
	);

	word_unpacker unpack0 (
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.fifo_out      (fifo_out),
		.empty         (empty),
		.fifo_rd       (fifo_rd),
		.pix           (pix),
		.pix_valid     (pix_valid)
	);

endmodule

/* source/word_unpacker.sv */
// Word to pixel unpacker
`timescale 1ns/1ps

module word_unpacker import video_pkg::*; (
	input  logic       M_AXI_ACLK,
	input  logic       M_AXI_ARESETN,

	input  fifo_word_t fifo_out,
	input  logic       empty,
	output logic       fifo_rd,

	output pixel_t     pix,
	output logic       pix_valid
);

	fifo_word_t           word_q;
	logic                 busy;
	logic [lane_bits-1:0] lane;
	logic                 last_lane;

	assign last_lane = (lane == lane_bits'(word_pixels - 1));

	// --------------------------------------------------
	// Pop control
	// --------------------------------------------------

	// Pop when idle, or on the last lane to keep one pixel per cycle
	assign fifo_rd = !empty && (!busy || last_lane);

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			busy <= 1'b0;
			lane <= '0;
		end else if (fifo_rd) begin
			busy <= 1'b1;
			lane <= '0;
		end else if (busy) begin
			if (last_lane)
				busy <= 1'b0;
			else
				lane <= lane + 1'b1;
		end
	end

	// Word held while its lanes go out
	always_ff @(posedge M_AXI_ACLK) begin
		if (fifo_rd)
			word_q <= fifo_out;
	end

	// --------------------------------------------------
	// Pixel output
	// --------------------------------------------------

	// Lowest byte first
	assign pix_valid = busy;
	assign pix = '{
		data: word_q.data[lane*pixel_width +: pixel_width],
		sof:  word_q.sof && (lane == '0),
		eol:  word_q.eol && last_lane
	};

endmodule

/* source/sync_fifo.sv */
// Single clock word FIFO
`timescale 1ns/1ps

module sync_fifo import video_pkg::*; #(
	parameter int depth = fifo_depth
) (
	input  logic       M_AXI_ACLK,
	input  logic       M_AXI_ARESETN,

	input  logic       wr,
	input  fifo_word_t din,

	input  logic       rd,
	output fifo_word_t dout,

	output logic       full,
	output logic       empty
);

	localparam int aw = $clog2(depth);

	fifo_word_t    mem [depth];

	// Extra top bit tells a full buffer from an empty one
	logic [aw:0]   wr_ptr;
	logic [aw:0]   rd_ptr;
	logic          do_wr;
	logic          do_rd;

	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);

	// --------------------------------------------------
	// Pointers
	// --------------------------------------------------
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// --------------------------------------------------
	// Storage
	// --------------------------------------------------
	always_ff @(posedge M_AXI_ACLK) begin
		if (do_wr)
			mem[wr_ptr[aw-1:0]] <= din;
	end

	// Show-ahead output
	assign dout = mem[rd_ptr[aw-1:0]];

endmodule

/* source/mm2fifo.sv */
// Frame burst read controller
`timescale 1ns/1ps

module mm2fifo import axi_rd_pkg::*, video_pkg::*; (
	input  logic                  M_AXI_ACLK,
	input  logic                  M_AXI_ARESETN,

	input  logic [img_wbits-1:0]  img_width,
	input  logic [img_hbits-1:0]  img_height,
	input  logic [addr_width-1:0] base_addr,
	input  logic                  fsync,
	output logic                  frame_pulse,

	output axi_ar_t               ar,
	output logic                  ar_valid,
	input  logic                  ar_ready,

	input  axi_r_t                r,
	input  logic                  r_valid,
	output logic                  r_ready,

	output fifo_word_t            fifo_in,
	output logic                  fifo_wr,
	input  logic                  full
);

	logic [addr_width-1:0] araddr;
	logic                  arvalid_q;
	logic                  start_burst;
	logic                  burst_active;
	logic                  rnext;
	logic                  final_word;
	logic                  sof_q;

	// Remaining words in the current row and remaining rows
	logic [img_wbits-1:0]  col_cnt;
	logic [img_hbits-1:0]  row_cnt;
	logic [img_wbits-1:0]  col_init;

	assign col_init = img_width / img_wbits'(word_pixels) - img_wbits'(1);
	assign final_word = (col_cnt == '0) && (row_cnt == '0);

	// --------------------------------------------------
	// Burst sequencing
	// --------------------------------------------------

	// Idle at frame end with a request pending
	assign frame_pulse = !start_burst && !burst_active && final_word && fsync;

	// One burst in flight at a time; a new frame waits for fsync
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			start_burst <= 1'b0;
		end else if (!start_burst && !burst_active && (!final_word || fsync)) begin
			start_burst <= 1'b1;
		end else begin
			start_burst <= 1'b0;
		end
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			burst_active <= 1'b0;
		end else if (start_burst) begin
			burst_active <= 1'b1;
		end else if (rnext && r.last) begin
			burst_active <= 1'b0;
		end
	end

	// --------------------------------------------------
	// Read address channel
	// --------------------------------------------------
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			arvalid_q <= 1'b0;
		end else if (!arvalid_q && start_burst) begin
			arvalid_q <= 1'b1;
		end else if (arvalid_q && ar_ready) begin
			arvalid_q <= 1'b0;
		end
	end

	// Base address is taken at each frame start
	always_ff @(posedge M_AXI_ACLK) begin
		if (start_burst) begin
			if (final_word)
				araddr <= base_addr;
			else
				araddr <= araddr + addr_width'(burst_bytes);
		end
	end

	assign ar_valid = arvalid_q;
	assign ar = '{
		addr:  araddr,
		len:   8'(burst_len - 1),
		size:  beat_size,
		burst: burst_incr,
		lock:  1'b0,
		cache: 4'h0,
		prot:  3'h0,
		qos:   4'h0
	};

	// --------------------------------------------------
	// Read data channel
	// --------------------------------------------------

	// Only FIFO fullness throttles the bus; resp is not checked
	assign r_ready = !full;
	assign rnext = r_valid && r_ready;

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (start_burst && final_word) begin
			col_cnt <= col_init;
			row_cnt <= img_height - img_hbits'(1);
		end else if (rnext) begin
			if (col_cnt != '0) begin
				col_cnt <= col_cnt - img_wbits'(1);
			end else if (row_cnt != '0) begin
				col_cnt <= col_init;
				row_cnt <= row_cnt - img_hbits'(1);
			end
		end
	end

	// Armed at frame start, dropped after the first beat
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			sof_q <= 1'b0;
		end else if (start_burst && final_word) begin
			sof_q <= 1'b1;
		end else if (rnext) begin
			sof_q <= 1'b0;
		end
	end

	assign fifo_wr = rnext;
	assign fifo_in = '{
		data: r.data,
		sof:  sof_q,
		eol:  (col_cnt == '0)
	};

endmodule

/* source/video_pkg.sv */
// Video stream definitions
package video_pkg;

	// --------------------------------------------------
	// Image geometry
	// --------------------------------------------------
	localparam int img_wbits = 12;
	localparam int img_hbits = 12;

	localparam int pixel_width = 8;
	localparam int word_pixels = 4;
	localparam int lane_bits = $clog2(word_pixels);

	// Words buffered between bus and pixel stream
	localparam int fifo_depth = 32;

	// --------------------------------------------------
	// Payloads
	// --------------------------------------------------

	// Word flags: sof on first word of frame, eol on last word of a row
	typedef struct packed {
		logic [pixel_width*word_pixels-1:0] data;
		logic                               sof;
		logic                               eol;
	} fifo_word_t;

	typedef struct packed {
		logic [pixel_width-1:0] data;
		logic                   sof;
		logic                   eol;
	} pixel_t;

endpackage

/* source/axi_rd_pkg.sv */
// AXI read bus definitions
package axi_rd_pkg;

	// --------------------------------------------------
	// Bus geometry
	// --------------------------------------------------
	localparam int addr_width = 32;
	localparam int data_width = 32;

	// Beats per burst, 16 keeps AXI3 slaves happy
	localparam int burst_len = 16;
	localparam int burst_bytes = burst_len * data_width / 8;

	// Fixed AR fields
	localparam logic [2:0] beat_size = 3'($clog2(data_width / 8));
	localparam logic [1:0] burst_incr = 2'b01;

	// --------------------------------------------------
	// Channel payloads
	// --------------------------------------------------

	// Read address channel
	typedef struct packed {
		logic [addr_width-1:0] addr;
		logic [7:0]            len;
		logic [2:0]            size;
		logic [1:0]            burst;
		logic                  lock;
		logic [3:0]            cache;
		logic [2:0]            prot;
		logic [3:0]            qos;
	} axi_ar_t;

	// Read data channel
	typedef struct packed {
		logic [data_width-1:0] data;
		logic [1:0]            resp;
		logic                  last;
	} axi_r_t;

endpackage
